/* source/roce_pkt_pkg.sv */
package roce_pkt_pkg;

  typedef logic [47:0]  mac_addr_t;
  typedef logic [31:0]  ipv4_addr_t;
  typedef logic [23:0]  qp_num_t;
  typedef logic [23:0]  psn_t;
  typedef logic [15:0]  csum_t;
  typedef logic [511:0] axis_data_t;  // byte 0 in lane 0
  typedef logic [63:0]  axis_keep_t;

  typedef enum logic {
    KIND_RD_RESP,
    KIND_ACK
  } pkt_kind_e;

  typedef struct packed {
    mac_addr_t  dst_mac;
    ipv4_addr_t dst_ip;
  } qp_cfg_t;

  typedef struct packed {
    pkt_kind_e kind;
    qp_num_t   qp;
    psn_t      psn;
  } resp_req_t;

  typedef struct packed {
    mac_addr_t  dst_mac;
    ipv4_addr_t dst_ip;
    csum_t      rd_csum;
    csum_t      ack_csum;
  } qp_ctx_t;

  // packet sizes in bytes
  localparam int RD_RESP_PKT_BYTES = 314;
  localparam int HDR_BYTES         = 58;
  localparam int BEAT_BYTES        = 64;

  typedef logic [HDR_BYTES*8-1:0] hdr_t;  // wire order, byte 0 at the top

  localparam logic [15:0] RD_RESP_TOTAL_LEN = 16'h0130;
  localparam logic [15:0] ACK_TOTAL_LEN     = 16'h0030;
  localparam logic [15:0] ETH_TYPE_IPV4     = 16'h0800;

  localparam logic [7:0]  IP_VER_IHL   = 8'h45;
  localparam logic [7:0]  IP_TOS       = 8'hb8;
  localparam logic [15:0] IP_ID        = 16'h5555;
  localparam logic [15:0] IP_FLAGS     = 16'h4000;  // don't fragment
  localparam logic [7:0]  IP_TTL       = 8'hba;
  localparam logic [7:0]  IP_PROTO_UDP = 8'h11;

  localparam logic [15:0] UDP_SRC_PORT = 16'h6851;
  localparam logic [15:0] UDP_DST_PORT = 16'h12b7;  // 4791, roce v2

  localparam logic [7:0]  OPC_RD_RESP = 8'h10;
  localparam logic [7:0]  OPC_ACK     = 8'h11;
  localparam logic [15:0] PKEY        = 16'h666f;

  // request descriptor field offsets
  localparam int REQ_PSN_BYTE = 51;
  localparam int REQ_QP_BYTE  = 47;

  function automatic csum_t ipv4_csum(input logic [15:0] total_len,
                                      input ipv4_addr_t src_ip,
                                      input ipv4_addr_t dst_ip);
    logic [19:0] sum;
    sum = 20'({IP_VER_IHL, IP_TOS}) + 20'(total_len) + 20'(IP_ID) + 20'(IP_FLAGS)
        + 20'({IP_TTL, IP_PROTO_UDP})
        + 20'(src_ip[31:16]) + 20'(src_ip[15:0])
        + 20'(dst_ip[31:16]) + 20'(dst_ip[15:0]);
    sum = 20'(sum[15:0]) + 20'(sum[19:16]);
    sum = 20'(sum[15:0]) + 20'(sum[19:16]);  // second fold catches the last carry
    return ~sum[15:0];
  endfunction

  // first header byte ends up in the lowest lane
  function automatic hdr_t hdr_to_lanes(input hdr_t hdr);
    hdr_t lanes;
    for (int i = 0; i < HDR_BYTES; i++) begin
      lanes[i*8 +: 8] = hdr[(HDR_BYTES-1-i)*8 +: 8];
    end
    return lanes;
  endfunction

endpackage

/* source/req_parser.sv */
`timescale 1ns/1ps
module req_parser import roce_pkt_pkg::*; #(
  parameter int NUM_QP   = 6,
  parameter int FIRST_QP = 2
) (
  input  logic              core_clk,
  input  logic              core_aresetn,
  input  logic              req_valid_i,
  input  logic              req_is_ack_i,
  input  axis_data_t        req_data_i,
  input  logic              take_i,
  output logic              req_ready_o,
  output logic              pend_valid_o,
  output resp_req_t         pend_o,
  output logic [NUM_QP-1:0] slot_sel_o,
  output logic              drop_o
);

  qp_num_t req_qp;
  psn_t    req_psn;
  logic    req_fire;
  logic    qp_known;

  // three bytes each, msb at the lower offset
  assign req_qp  = {req_data_i[REQ_QP_BYTE*8 +: 8],
                    req_data_i[(REQ_QP_BYTE+1)*8 +: 8],
                    req_data_i[(REQ_QP_BYTE+2)*8 +: 8]};
  assign req_psn = {req_data_i[REQ_PSN_BYTE*8 +: 8],
                    req_data_i[(REQ_PSN_BYTE+1)*8 +: 8],
                    req_data_i[(REQ_PSN_BYTE+2)*8 +: 8]};

  assign req_ready_o = !pend_valid_o;  // one request buffered
  assign req_fire    = req_valid_i && req_ready_o;
  assign qp_known    = (req_qp >= qp_num_t'(FIRST_QP)) &&
                       (req_qp < qp_num_t'(FIRST_QP + NUM_QP));

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      pend_valid_o <= 1'b0;
      drop_o       <= 1'b0;
    end else begin
      drop_o <= req_fire && !qp_known;
      if (req_fire && qp_known) begin
        pend_valid_o <= 1'b1;
      end else if (take_i) begin
        pend_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (req_fire) begin
      pend_o.kind <= req_is_ack_i ? KIND_ACK : KIND_RD_RESP;
      pend_o.qp   <= req_qp;
      pend_o.psn  <= req_psn;
    end
  end

  // select for the context mux
  for (genvar i = 0; i < NUM_QP; i++) begin : g_sel
    assign slot_sel_o[i] = pend_valid_o && (pend_o.qp == qp_num_t'(FIRST_QP + i));
  end

endmodule

/* source/qp_ctx_slot.sv */
`timescale 1ns/1ps
module qp_ctx_slot import roce_pkt_pkg::*; #(
  parameter int SLOT_QP = 2
) (
  input  logic       core_clk,
  input  logic       core_aresetn,
  input  logic       cfg_we_i,
  input  qp_num_t    cfg_qp_i,
  input  qp_cfg_t    cfg_i,
  input  ipv4_addr_t src_ip_i,
  output qp_ctx_t    ctx_o
);

  logic  cfg_hit;
  csum_t rd_csum;
  csum_t ack_csum;

  assign cfg_hit = cfg_we_i && (cfg_qp_i == qp_num_t'(SLOT_QP));

  // only the total length differs between the two kinds,
  // so both sums are ready before any request shows up
  assign rd_csum  = ipv4_csum(RD_RESP_TOTAL_LEN, src_ip_i, cfg_i.dst_ip);
  assign ack_csum = ipv4_csum(ACK_TOTAL_LEN, src_ip_i, cfg_i.dst_ip);

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      ctx_o <= '0;
    end else if (cfg_hit) begin
      ctx_o.dst_mac  <= cfg_i.dst_mac;
      ctx_o.dst_ip   <= cfg_i.dst_ip;
      ctx_o.rd_csum  <= rd_csum;
      ctx_o.ack_csum <= ack_csum;  // reconfig overwrites both
    end
  end

endmodule

/* source/pkt_serializer.sv */
`timescale 1ns/1ps
module pkt_serializer import roce_pkt_pkg::*; (
  input  logic       core_clk,
  input  logic       core_aresetn,
  input  logic       pend_valid_i,
  input  resp_req_t  pend_i,
  input  qp_ctx_t    ctx_i,
  input  mac_addr_t  src_mac_i,
  input  ipv4_addr_t src_ip_i,
  input  logic       tx_tready_i,
  output logic       take_o,
  output axis_data_t tx_tdata_o,
  output axis_keep_t tx_tkeep_o,
  output logic       tx_tvalid_o,
  output logic       tx_tlast_o
);

  localparam int MAX_BEATS = (RD_RESP_PKT_BYTES + BEAT_BYTES - 1) / BEAT_BYTES;
  localparam int PAY_BYTES = RD_RESP_PKT_BYTES - HDR_BYTES;
  localparam int BEAT_BITS = BEAT_BYTES * 8;
  localparam int PKT_BITS  = MAX_BEATS * BEAT_BITS;
  localparam int REM_W     = $clog2(RD_RESP_PKT_BYTES + 1);
  localparam int BEAT_W    = $clog2(MAX_BEATS);

  typedef enum logic [1:0] {
    SER_IDLE,
    SER_LOAD,
    SER_BEAT
  } ser_state_e;

  ser_state_e          state_q;
  resp_req_t           req_q;
  qp_ctx_t             ctx_q;
  logic [PKT_BITS-1:0] pkt_q;     // whole packet in lane order
  logic [REM_W-1:0]    remain_q;  // bytes still to go out
  logic [BEAT_W-1:0]   beat_q;

  logic                is_ack;
  logic [15:0]         total_len;
  logic [15:0]         udp_len;
  csum_t               csum;
  logic [7:0]          opcode;
  logic [7:0]          pay_byte;
  hdr_t                hdr;
  logic [PKT_BITS-1:0] pkt_d;
  logic                last_beat;
  axis_keep_t          keep_last;

  assign take_o = (state_q == SER_IDLE) && pend_valid_i && tx_tready_i;

  assign is_ack    = (req_q.kind == KIND_ACK);
  assign total_len = is_ack ? ACK_TOTAL_LEN : RD_RESP_TOTAL_LEN;
  assign udp_len   = total_len - 16'd20;
  assign csum      = is_ack ? ctx_q.ack_csum : ctx_q.rd_csum;
  assign opcode    = is_ack ? OPC_ACK : OPC_RD_RESP;
  assign pay_byte  = {4'h1, req_q.psn[3:0] + 4'h1};

  // eth, ipv4, udp, bth, aeth
  assign hdr = {ctx_q.dst_mac, src_mac_i, ETH_TYPE_IPV4,
                IP_VER_IHL, IP_TOS, total_len, IP_ID, IP_FLAGS,
                IP_TTL, IP_PROTO_UDP, csum, src_ip_i, ctx_q.dst_ip,
                UDP_SRC_PORT, UDP_DST_PORT, udp_len, 16'h0000,
                opcode, 8'h00, PKEY, 8'h00, req_q.qp, 8'h00, req_q.psn,
                32'h0000_0000};

  assign pkt_d = is_ack ? PKT_BITS'(hdr_to_lanes(hdr))
                        : PKT_BITS'({{PAY_BYTES{pay_byte}}, hdr_to_lanes(hdr)});

  assign last_beat = (remain_q <= REM_W'(BEAT_BYTES));
  assign keep_last = ~(axis_keep_t'('1) << remain_q);

  // nothing moves while the sink holds off
  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state_q     <= SER_IDLE;
      remain_q    <= '0;
      beat_q      <= '0;
      tx_tkeep_o  <= '0;
      tx_tvalid_o <= 1'b0;
      tx_tlast_o  <= 1'b0;
    end else if (tx_tready_i) begin
      case (state_q)
        SER_IDLE: begin
          tx_tvalid_o <= 1'b0;  // last beat went out on this edge
          tx_tlast_o  <= 1'b0;
          if (pend_valid_i) begin
            state_q <= SER_LOAD;
          end
        end
        SER_LOAD: begin
          remain_q <= is_ack ? REM_W'(HDR_BYTES) : REM_W'(RD_RESP_PKT_BYTES);
          beat_q   <= '0;
          state_q  <= SER_BEAT;
        end
        SER_BEAT: begin
          tx_tvalid_o <= 1'b1;
          beat_q      <= beat_q + 1'b1;
          if (last_beat) begin
            tx_tkeep_o <= keep_last;
            tx_tlast_o <= 1'b1;
            state_q    <= SER_IDLE;
          end else begin
            tx_tkeep_o <= '1;
            remain_q   <= remain_q - REM_W'(BEAT_BYTES);
          end
        end
        default: state_q <= SER_IDLE;
      endcase
    end
  end

  always_ff @(posedge core_clk) begin
    if (take_o) begin
      req_q <= pend_i;
      ctx_q <= ctx_i;
    end
    if (tx_tready_i && state_q == SER_LOAD) begin
      pkt_q <= pkt_d;
    end
    if (tx_tready_i && state_q == SER_BEAT) begin
      tx_tdata_o <= pkt_q[beat_q*BEAT_BITS +: BEAT_BITS];
    end
  end

endmodule

/* source/roce_resp_gen_top.sv */
`timescale 1ns/1ps
module roce_resp_gen_top import roce_pkt_pkg::*; #(
  parameter int NUM_QP   = 6,
  parameter int FIRST_QP = 2
) (
  input  logic       core_clk,
  input  logic       core_aresetn,
  input  mac_addr_t  src_mac_i,
  input  ipv4_addr_t src_ip_i,
  input  logic       cfg_we_i,
  input  qp_num_t    cfg_qp_i,
  input  qp_cfg_t    cfg_i,
  input  logic       req_valid_i,
  input  logic       req_is_ack_i,
  input  axis_data_t req_data_i,
  output logic       req_ready_o,
  output logic       drop_o,
  output axis_data_t tx_tdata_o,
  output axis_keep_t tx_tkeep_o,
  output logic       tx_tvalid_o,
  output logic       tx_tlast_o,
  input  logic       tx_tready_i
);

  logic              pend_valid;
  resp_req_t         pend;
  logic              take;
  logic [NUM_QP-1:0] slot_sel;
  qp_ctx_t           slot_ctx [NUM_QP];
  qp_ctx_t           sel_ctx;

  req_parser #(
    .NUM_QP   (NUM_QP),
    .FIRST_QP (FIRST_QP)
  ) u_parser (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .req_valid_i  (req_valid_i),
    .req_is_ack_i (req_is_ack_i),
    .req_data_i   (req_data_i),
    .take_i       (take),
    .req_ready_o  (req_ready_o),
    .pend_valid_o (pend_valid),
    .pend_o       (pend),
    .slot_sel_o   (slot_sel),
    .drop_o       (drop_o)
  );

  for (genvar i = 0; i < NUM_QP; i++) begin : g_slot
    qp_ctx_slot #(
      .SLOT_QP (FIRST_QP + i)
    ) u_slot (
      .core_clk     (core_clk),
      .core_aresetn (core_aresetn),
      .cfg_we_i     (cfg_we_i),
      .cfg_qp_i     (cfg_qp_i),
      .cfg_i        (cfg_i),
      .src_ip_i     (src_ip_i),
      .ctx_o        (slot_ctx[i])
    );
  end

  // one-hot pick of the pending qp's context
  always_comb begin
    sel_ctx = '0;
    for (int i = 0; i < NUM_QP; i++) begin
      if (slot_sel[i]) begin
        sel_ctx = slot_ctx[i];
      end
    end
  end

  pkt_serializer u_serializer (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .pend_valid_i (pend_valid),
    .pend_i       (pend),
    .ctx_i        (sel_ctx),
    .src_mac_i    (src_mac_i),
    .src_ip_i     (src_ip_i),
    .tx_tready_i  (tx_tready_i),
    .take_o       (take),
    .tx_tdata_o   (tx_tdata_o),
    .tx_tkeep_o   (tx_tkeep_o),
    .tx_tvalid_o  (tx_tvalid_o),
    .tx_tlast_o   (tx_tlast_o)
  );

endmodule

/* tb/tb_roce_resp_gen.sv */
`timescale 1ns/1ps
module tb_roce_resp_gen import roce_pkt_pkg::*; ();

  localparam int          NUM_QP   = 6;
  localparam int          FIRST_QP = 2;
  localparam int          MAX_OPS  = 64;
  localparam logic [47:0] SRC_MAC  = 48'h02_00_5e_00_00_01;
  localparam logic [31:0] SRC_IP   = 32'h0a00_0001;  // file checksums are worked out for this

  typedef struct packed {
    pkt_kind_e  kind;
    qp_num_t    qp;
    psn_t       psn;
    mac_addr_t  mac;
    ipv4_addr_t ip;
    csum_t      csum;
  } exp_pkt_t;

  logic       core_clk;
  logic       core_aresetn;
  mac_addr_t  src_mac_i;
  ipv4_addr_t src_ip_i;
  logic       cfg_we_i;
  qp_num_t    cfg_qp_i;
  qp_cfg_t    cfg_i;
  logic       req_valid_i;
  logic       req_is_ack_i;
  axis_data_t req_data_i;
  logic       req_ready_o;
  logic       drop_o;
  axis_data_t tx_tdata_o;
  axis_keep_t tx_tkeep_o;
  logic       tx_tvalid_o;
  logic       tx_tlast_o;
  logic       tx_tready_i;

  // one entry per stimulus line
  int         num_ops;
  int         num_req;
  logic       op_is_cfg   [MAX_OPS];
  qp_num_t    op_qp       [MAX_OPS];
  mac_addr_t  op_mac      [MAX_OPS];
  ipv4_addr_t op_ip       [MAX_OPS];
  csum_t      op_rd_csum  [MAX_OPS];
  csum_t      op_ack_csum [MAX_OPS];
  logic       op_ack      [MAX_OPS];
  psn_t       op_psn      [MAX_OPS];
  logic       op_drop     [MAX_OPS];

  mac_addr_t  slot_mac [NUM_QP];  // model of what each slot holds
  ipv4_addr_t slot_ip  [NUM_QP];
  csum_t      slot_rd  [NUM_QP];
  csum_t      slot_ack [NUM_QP];

  exp_pkt_t   exp_q [$];
  exp_pkt_t   cur_pkt;
  logic       in_pkt;
  int         beat_idx;
  integer     seed;
  int         cycle_count;
  int         cycle_limit;

  roce_resp_gen_top #(
    .NUM_QP   (NUM_QP),
    .FIRST_QP (FIRST_QP)
  ) DUT (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .src_mac_i    (src_mac_i),
    .src_ip_i     (src_ip_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_qp_i     (cfg_qp_i),
    .cfg_i        (cfg_i),
    .req_valid_i  (req_valid_i),
    .req_is_ack_i (req_is_ack_i),
    .req_data_i   (req_data_i),
    .req_ready_o  (req_ready_o),
    .drop_o       (drop_o),
    .tx_tdata_o   (tx_tdata_o),
    .tx_tkeep_o   (tx_tkeep_o),
    .tx_tvalid_o  (tx_tvalid_o),
    .tx_tlast_o   (tx_tlast_o),
    .tx_tready_i  (tx_tready_i)
  );

  always #20 core_clk = ~core_clk;

  always @(posedge core_clk) begin
    #2;
    tx_tready_i = ($random(seed) % 4) != 0;  // roughly three cycles in four
  end

  always @(posedge core_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      raise_error($sformatf("timeout, no finish after %0d cycles", cycle_count));
    end
  end

  task automatic raise_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      raise_error($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_csum(input string name, input csum_t got, input csum_t exp);
    if (got !== exp) begin
      raise_error($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_beat(input string where, input axis_data_t got_data,
                            input axis_keep_t got_keep, input axis_data_t exp_data,
                            input axis_keep_t exp_keep);
    axis_data_t mask;
    if (got_keep !== exp_keep) begin
      raise_error($sformatf("Mismatch tx_tkeep_o at %s: got 0x%h expected 0x%h",
                            where, got_keep, exp_keep));
    end
    mask = '0;
    for (int i = 0; i < BEAT_BYTES; i++) begin
      if (exp_keep[i]) begin
        mask[i*8 +: 8] = 8'hff;  // only valid lanes count
      end
    end
    if ((got_data & mask) !== (exp_data & mask)) begin
      raise_error($sformatf("Mismatch tx_tdata_o at %s: got 0x%h expected 0x%h",
                            where, got_data & mask, exp_data & mask));
    end
  endtask

  function automatic int pkt_len(input exp_pkt_t p);
    return (p.kind == KIND_ACK) ? 58 : 314;
  endfunction

  // byte n of the packet on the wire
  function automatic logic [7:0] pkt_byte(input exp_pkt_t p, input int n);
    logic [15:0]  tot;
    logic [23:0]  psn_inc;
    logic [463:0] hdr;
    tot     = (p.kind == KIND_ACK) ? 16'h0030 : 16'h0130;
    psn_inc = p.psn + 24'd1;
    hdr = {p.mac, SRC_MAC, 16'h0800,
           8'h45, 8'hb8, tot, 16'h5555, 16'h4000, 8'hba, 8'h11, p.csum, SRC_IP, p.ip,
           16'h6851, 16'h12b7, tot - 16'd20, 16'h0000,
           (p.kind == KIND_ACK) ? 8'h11 : 8'h10, 8'h00, 16'h666f,
           8'h00, p.qp, 8'h00, p.psn,
           32'h0000_0000};
    if (n < 58) begin
      return hdr[(57-n)*8 +: 8];
    end else if (p.kind == KIND_RD_RESP && n < 314) begin
      return {4'h1, psn_inc[3:0]};
    end
    return 8'h00;
  endfunction

  function automatic axis_data_t build_beat(input exp_pkt_t p, input int beat);
    axis_data_t d;
    for (int lane = 0; lane < BEAT_BYTES; lane++) begin
      d[lane*8 +: 8] = pkt_byte(p, beat * BEAT_BYTES + lane);
    end
    return d;
  endfunction

  function automatic axis_keep_t build_keep(input exp_pkt_t p, input int beat);
    axis_keep_t k;
    for (int lane = 0; lane < BEAT_BYTES; lane++) begin
      k[lane] = (beat * BEAT_BYTES + lane) < pkt_len(p);
    end
    return k;
  endfunction

  task automatic load_stimulus();
    integer           fd;
    integer           code;
    logic [63:0]      tag;
    logic [8*128-1:0] line;
    logic [23:0]      f_qp;
    logic [47:0]      f_mac;
    logic [31:0]      f_ip;
    logic [15:0]      f_rd;
    logic [15:0]      f_ack;
    logic [23:0]      f_psn;
    integer           f_kind;
    integer           f_drop;
    fd = $fopen("tb/resp_gen_stimulus.txt", "r");
    if (fd == 0) begin
      raise_error("could not open tb/resp_gen_stimulus.txt");
    end
    num_ops = 0;
    num_req = 0;
    while (!$feof(fd)) begin
      tag  = '0;
      code = $fscanf(fd, "%s", tag);
      if (code == 1) begin
        if (tag == "#") begin
          code = $fgets(line, fd);
        end else if (tag == "C") begin
          code = $fscanf(fd, "%h %h %h %h %h", f_qp, f_mac, f_ip, f_rd, f_ack);
          if (code != 5 || f_qp < FIRST_QP || f_qp >= FIRST_QP + NUM_QP) begin
            raise_error("bad config line in stimulus file");
          end
          op_is_cfg[num_ops]   = 1'b1;
          op_qp[num_ops]       = f_qp;
          op_mac[num_ops]      = f_mac;
          op_ip[num_ops]       = f_ip;
          op_rd_csum[num_ops]  = f_rd;
          op_ack_csum[num_ops] = f_ack;
          num_ops++;
        end else if (tag == "R") begin
          code = $fscanf(fd, "%d %h %h %d", f_kind, f_qp, f_psn, f_drop);
          if (code != 4) begin
            raise_error("bad request line in stimulus file");
          end
          if ((f_drop != 0) != (f_qp < FIRST_QP || f_qp >= FIRST_QP + NUM_QP)) begin
            raise_error("drop flag in stimulus file disagrees with the QP range");
          end
          op_is_cfg[num_ops] = 1'b0;
          op_ack[num_ops]    = (f_kind != 0);
          op_qp[num_ops]     = f_qp;
          op_psn[num_ops]    = f_psn;
          op_drop[num_ops]   = (f_drop != 0);
          num_ops++;
          num_req++;
        end else begin
          raise_error("unknown line tag in stimulus file");
        end
      end
    end
    $fclose(fd);
    cycle_limit = 40 * num_req + 200;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0 || in_pkt) begin
      @(negedge core_clk);
    end
  endtask

  task automatic write_config(input int idx);
    int slot;
    slot = op_qp[idx] - FIRST_QP;
    wait_drained();  // a packet copies its context when it starts
    @(posedge core_clk);
    #2;
    cfg_we_i       = 1'b1;
    cfg_qp_i       = op_qp[idx];
    cfg_i.dst_mac  = op_mac[idx];
    cfg_i.dst_ip   = op_ip[idx];
    slot_mac[slot] = op_mac[idx];
    slot_ip[slot]  = op_ip[idx];
    slot_rd[slot]  = op_rd_csum[idx];
    slot_ack[slot] = op_ack_csum[idx];
    @(posedge core_clk);
    #2;
    cfg_we_i = 1'b0;
  endtask

  task automatic send_request(input int idx);
    axis_data_t d;
    exp_pkt_t   p;
    logic [7:0] fill;
    int         slot;
    fill = 8'h5a;
    for (int i = 0; i < BEAT_BYTES; i++) begin
      d[i*8 +: 8] = fill;  // filler the parser ignores
      fill = fill + 8'd3;
    end
    d[47*8 +: 8] = op_qp[idx][23:16];  // qp msb first
    d[48*8 +: 8] = op_qp[idx][15:8];
    d[49*8 +: 8] = op_qp[idx][7:0];
    d[51*8 +: 8] = op_psn[idx][23:16];
    d[52*8 +: 8] = op_psn[idx][15:8];
    d[53*8 +: 8] = op_psn[idx][7:0];
    slot   = op_qp[idx] - FIRST_QP;
    p      = '0;
    p.kind = op_ack[idx] ? KIND_ACK : KIND_RD_RESP;
    p.qp   = op_qp[idx];
    p.psn  = op_psn[idx];
    if (!op_drop[idx]) begin
      p.mac  = slot_mac[slot];
      p.ip   = slot_ip[slot];
      p.csum = op_ack[idx] ? slot_ack[slot] : slot_rd[slot];
    end
    req_valid_i  = 1'b1;
    req_is_ack_i = op_ack[idx];
    req_data_i   = d;
    @(negedge core_clk);
    while (!req_ready_o) begin
      @(negedge core_clk);
    end
    @(posedge core_clk);  // accepted on this edge
    if (!op_drop[idx]) begin
      exp_q.push_back(p);
    end
    #2;
    req_valid_i = 1'b0;
    @(negedge core_clk);
    check_flag("drop_o", drop_o, op_drop[idx]);
    @(posedge core_clk);
    #2;
  endtask

  // beats are checked where tvalid and tready are settled
  always @(negedge core_clk) begin
    if (core_aresetn && tx_tvalid_o && tx_tready_i) begin
      if (!in_pkt) begin
        if (exp_q.size() == 0) begin
          raise_error("beat on the tx stream while no packet was outstanding");
        end
        cur_pkt  = exp_q.pop_front();
        beat_idx = 0;
        in_pkt   = 1'b1;
        check_csum("ipv4 checksum in tx_tdata_o bytes 24-25",
                   {tx_tdata_o[24*8 +: 8], tx_tdata_o[25*8 +: 8]}, cur_pkt.csum);
      end
      check_beat($sformatf("beat %0d, qp 0x%h psn 0x%h", beat_idx, cur_pkt.qp, cur_pkt.psn),
                 tx_tdata_o, tx_tkeep_o, build_beat(cur_pkt, beat_idx),
                 build_keep(cur_pkt, beat_idx));
      check_flag("tx_tlast_o", tx_tlast_o, (beat_idx + 1) * BEAT_BYTES >= pkt_len(cur_pkt));
      if (tx_tlast_o) begin
        in_pkt = 1'b0;
      end else begin
        beat_idx = beat_idx + 1;
      end
    end
  end

  initial begin
    core_clk     = 1'b0;
    core_aresetn = 1'b0;
    src_mac_i    = SRC_MAC;
    src_ip_i     = SRC_IP;
    cfg_we_i     = 1'b0;
    cfg_qp_i     = '0;
    cfg_i        = '0;
    req_valid_i  = 1'b0;
    req_is_ack_i = 1'b0;
    req_data_i   = '0;
    tx_tready_i  = 1'b0;
    seed         = 63448;
    cycle_count  = 0;
    cycle_limit  = 200;
    in_pkt       = 1'b0;
    beat_idx     = 0;
    load_stimulus();
    repeat (2) @(negedge core_clk);
    check_flag("tx_tvalid_o", tx_tvalid_o, 1'b0);
    check_flag("tx_tlast_o", tx_tlast_o, 1'b0);
    check_flag("drop_o", drop_o, 1'b0);
    check_flag("req_ready_o", req_ready_o, 1'b1);
    @(posedge core_clk);  // third reset cycle
    #2;
    core_aresetn = 1'b1;
    @(posedge core_clk);
    #2;
    for (int i = 0; i < num_ops; i++) begin
      if (op_is_cfg[i]) begin
        write_config(i);
      end else begin
        send_request(i);
      end
    end
    wait_drained();
    repeat (20) @(negedge core_clk);  // stray beats would hit the monitor here
    $display("Test OK");
    $finish;
  end

endmodule

/* tb/resp_gen_stimulus.txt */
# C qp dst_mac dst_ip rd_resp_csum ack_csum   (checksums for source ip 0a000001)
# R kind(0 read response, 1 ack) qp psn drop
C 000002 0a1b2c3d4e02 0a000002 55ad 56ad
C 000003 0a1b2c3d4e03 c0a80103 9e03 9f03
C 000005 0a1b2c3d4e05 ac100005 b399 b499
C 000007 0a1b2c3d4e07 0a0000ff 54b0 55b0
R 0 000002 000000 0
R 1 000002 000001 0
R 0 000003 00abcd 0
R 1 000003 00abce 0
R 0 000005 12345f 0
R 1 000007 fffffe 0
R 0 000007 ffffff 0
R 0 000001 000010 1
R 1 000002 000011 0
R 0 000008 000020 1
R 1 000000 000021 1
R 0 000005 000022 0
R 0 000003 000023 0
R 1 000005 000024 0
R 0 000002 000025 0
R 1 000003 000026 0
C 000003 0a1b2c3d4e33 ffffffff 5faf 60af
R 0 000003 000030 0
R 1 000003 000031 0
R 0 000002 000032 0
R 1 000103 000033 1
R 0 000003 000034 0
R 1 000007 000035 0
R 0 000005 000036 0

/* sim.f */
source/roce_pkt_pkg.sv
source/req_parser.sv
source/qp_ctx_slot.sv
source/pkt_serializer.sv
source/roce_resp_gen_top.sv
tb/tb_roce_resp_gen.sv
